/* logic/strm_consts.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, LFSR constants and AXI4-Lite response codes for the
// stream pattern engine; include where a macro is needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef STRM_CONSTS_SVH
`define STRM_CONSTS_SVH

// stream word
`define STRM_DATA_W 32
`define STRM_STRB_W 4 // one strobe bit per byte

// galois LFSR, shift right, xor taps when lsb falls out
`define STRM_LFSR_POLY 32'h8020_0003
`define STRM_SEED_RST 32'h1 // seed after reset, never zero

// AXI4-Lite register bus
`define AXIL_ADDR_W 5
`define AXIL_RESP_OKAY 2'b00
`define AXIL_RESP_SLVERR 2'b10

`endif

/* logic/strm_types_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream-side types used by the datapath blocks and the top
// level, referenced as strm_types_pkg::name
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "strm_consts.svh"

package strm_types_pkg;

  // byte strobe of one stream word, bit i enables byte i
  typedef logic [`STRM_STRB_W-1:0] strb_t;

  // number of low bytes dropped on the first beat of a packet
  // 0 keeps the whole word, 3 keeps only the top byte
  typedef logic [1:0] rot_t;

  // bubble pattern, one bit per cycle
  // 1 means no new beat that cycle unless forced
  typedef logic [7:0] stall_mask_t;

endpackage

/* logic/strm_regs_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register map of the AXI4-Lite slave and the layout of the
// CTRL and PKT words as seen by software
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "strm_consts.svh"

package strm_regs_pkg;

  // byte offsets, word aligned
  typedef enum logic [`AXIL_ADDR_W-1:0] {
    REG_CTRL  = 5'h00, // control bits
    REG_SEED  = 5'h04, // LFSR seed used on reseed
    REG_STALL = 5'h08, // bubble mask
    REG_PKT   = 5'h0C, // packet length and rotation
    REG_BEATS = 5'h10, // accepted beat count, read only
    REG_SIG   = 5'h14  // rotate-xor signature, read only
  } reg_addr_e;

  // CTRL word, bit 0 upward
  typedef struct packed {
    logic [27:0] rsvd;          // reads as zero
    logic        reseed;        // self clearing
    logic        force_invalid; // blocks new beats
    logic        force_valid;   // ignores the stall mask
    logic        enable;
  } ctrl_cfg_t;

  // PKT word
  typedef struct packed {
    logic [13:0]         rsvd;
    strm_types_pkg::rot_t rot; // bits 17:16
    logic [15:0]         len;  // beats per packet, 0 acts as 1
  } pkt_cfg_t;

endpackage

/* logic/strm_stream_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// valid/ready stream with byte strobes; a beat moves on a
// clock edge with valid and ready both high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "strm_consts.svh"

interface strm_stream_if;

  logic [`STRM_DATA_W-1:0] data;
  strm_types_pkg::strb_t   strb;
  logic                    valid;
  logic                    ready;

  // producer side, holds valid and data until accepted
  modport source (
    output data, strb, valid,
    input  ready
  );

  modport sink (
    input  data, strb, valid,
    output ready
  );

  // passive observer
  modport monitor (
    input data, strb, valid, ready
  );

endinterface

/* logic/strm_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite slave with the engine's register file; drives the
// datapath configuration and reads back beat count and signature
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "strm_consts.svh"

module strm_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [`AXIL_ADDR_W-1:0]           s_axil_awaddr_i,
  input  logic                              s_axil_awvalid_i,
  output logic                              s_axil_awready_o,
  input  logic [31:0]                       s_axil_wdata_i,
  input  logic [3:0]                        s_axil_wstrb_i,
  input  logic                              s_axil_wvalid_i,
  output logic                              s_axil_wready_o,
  output logic [1:0]                        s_axil_bresp_o,
  output logic                              s_axil_bvalid_o,
  input  logic                              s_axil_bready_i,
  input  logic [`AXIL_ADDR_W-1:0]           s_axil_araddr_i,
  input  logic                              s_axil_arvalid_i,
  output logic                              s_axil_arready_o,
  output logic [31:0]                       s_axil_rdata_o,
  output logic [1:0]                        s_axil_rresp_o,
  output logic                              s_axil_rvalid_o,
  input  logic                              s_axil_rready_i,
  output strm_regs_pkg::ctrl_cfg_t          ctrl_o,
  output logic [31:0]                       seed_o,
  output strm_types_pkg::stall_mask_t       stall_mask_o,
  output strm_regs_pkg::pkt_cfg_t           pkt_o,
  input  logic [31:0]                       beats_i,
  input  logic [31:0]                       sig_i
);

  // byte-wise merge of a write into the old register word
  function automatic logic [31:0] merge_strb(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  strm_regs_pkg::ctrl_cfg_t    ctrl_q;
  logic [31:0]                 seed_q;
  strm_types_pkg::stall_mask_t stall_q;
  strm_regs_pkg::pkt_cfg_t     pkt_q;

  // write channel capture, aw and w may come in either order
  logic [`AXIL_ADDR_W-1:0] awaddr_q;
  logic [31:0]             wdata_q;
  logic [3:0]              wstrb_q;
  logic                    aw_got_q, w_got_q;
  logic                    bvalid_q, rvalid_q;
  logic [1:0]              bresp_q, rresp_q;
  logic [31:0]             rdata_q;

  logic                    aw_hs, w_hs, ar_hs;
  logic                    aw_have, w_have, do_wr;
  logic [`AXIL_ADDR_W-1:0] wr_addr;
  logic [31:0]             wr_data;
  logic [3:0]              wr_strb;
  logic [31:0]             rd_word;
  logic                    rd_err;

  strm_regs_pkg::ctrl_cfg_t ctrl_wr; // CTRL after the byte merge
  strm_regs_pkg::pkt_cfg_t  pkt_wr;  // PKT after the byte merge

  // a captured address waits for its data instead of being overwritten
  assign s_axil_awready_o = ~bvalid_q & ~aw_got_q;
  assign s_axil_wready_o  = ~bvalid_q & ~w_got_q;
  assign s_axil_arready_o = ~rvalid_q;

  assign aw_hs = s_axil_awvalid_i & s_axil_awready_o;
  assign w_hs  = s_axil_wvalid_i & s_axil_wready_o;
  assign ar_hs = s_axil_arvalid_i & s_axil_arready_o;

  assign aw_have = aw_got_q | aw_hs;
  assign w_have  = w_got_q | w_hs;
  assign do_wr   = aw_have & w_have; // both halves present this edge

  assign wr_addr = aw_got_q ? awaddr_q : s_axil_awaddr_i;
  assign wr_data = w_got_q ? wdata_q : s_axil_wdata_i;
  assign wr_strb = w_got_q ? wstrb_q : s_axil_wstrb_i;

  assign ctrl_wr = merge_strb(ctrl_q, wr_data, wr_strb);
  assign pkt_wr  = merge_strb(pkt_q, wr_data, wr_strb);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      aw_got_q <= 1'b0;
      w_got_q  <= 1'b0;
      bvalid_q <= 1'b0;
      bresp_q  <= `AXIL_RESP_OKAY;
      ctrl_q   <= '0;
      seed_q   <= `STRM_SEED_RST;
      stall_q  <= '0;
      pkt_q    <= '0;
    end else begin
      ctrl_q.reseed <= 1'b0; // one-cycle pulse
      if (aw_hs) awaddr_q <= s_axil_awaddr_i;
      if (w_hs) begin
        wdata_q <= s_axil_wdata_i;
        wstrb_q <= s_axil_wstrb_i;
      end
      if (do_wr) begin
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
        bvalid_q <= 1'b1;
        bresp_q  <= `AXIL_RESP_OKAY;
        case (wr_addr)
          strm_regs_pkg::REG_CTRL: begin
            ctrl_q.enable        <= ctrl_wr.enable;
            ctrl_q.force_valid   <= ctrl_wr.force_valid;
            ctrl_q.force_invalid <= ctrl_wr.force_invalid;
            ctrl_q.reseed        <= ctrl_wr.reseed;
          end
          strm_regs_pkg::REG_SEED:  seed_q <= merge_strb(seed_q, wr_data, wr_strb);
          strm_regs_pkg::REG_STALL: stall_q <= wr_strb[0] ? wr_data[7:0] : stall_q;
          strm_regs_pkg::REG_PKT: begin
            pkt_q.len <= pkt_wr.len;
            pkt_q.rot <= pkt_wr.rot;
          end
          default: bresp_q <= `AXIL_RESP_SLVERR; // BEATS, SIG, holes
        endcase
      end else begin
        if (aw_hs) aw_got_q <= 1'b1;
        if (w_hs) w_got_q <= 1'b1;
        if (bvalid_q && s_axil_bready_i) bvalid_q <= 1'b0;
      end
    end
  end

  // read mux, sampled on the ar handshake
  always_comb begin
    rd_word = '0;
    rd_err  = 1'b0;
    case (s_axil_araddr_i)
      strm_regs_pkg::REG_CTRL:  rd_word = ctrl_q;
      strm_regs_pkg::REG_SEED:  rd_word = seed_q;
      strm_regs_pkg::REG_STALL: rd_word = {24'd0, stall_q};
      strm_regs_pkg::REG_PKT:   rd_word = pkt_q;
      strm_regs_pkg::REG_BEATS: rd_word = beats_i;
      strm_regs_pkg::REG_SIG:   rd_word = sig_i;
      default:                  rd_err  = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      rresp_q  <= `AXIL_RESP_OKAY;
    end else if (ar_hs) begin
      rvalid_q <= 1'b1;
      rdata_q  <= rd_word;
      rresp_q  <= rd_err ? `AXIL_RESP_SLVERR : `AXIL_RESP_OKAY;
    end else if (rvalid_q && s_axil_rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  assign s_axil_bvalid_o = bvalid_q;
  assign s_axil_bresp_o  = bresp_q;
  assign s_axil_rvalid_o = rvalid_q;
  assign s_axil_rdata_o  = rdata_q;
  assign s_axil_rresp_o  = rresp_q;

  assign ctrl_o       = ctrl_q;
  assign seed_o       = seed_q;
  assign stall_mask_o = stall_q;
  assign pkt_o        = pkt_q;

  // responses are held until the master takes them
  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (s_axil_bvalid_o && !s_axil_bready_i) |=> s_axil_bvalid_o);
  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (s_axil_rvalid_o && !s_axil_rready_i) |=> s_axil_rvalid_o && $stable(s_axil_rdata_o));

endmodule

/* logic/strm_reservoir_src.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pseudo-random beat source; a galois LFSR feeds one output
// register, a rotating mask and two force bits shape the flow
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "strm_consts.svh"

module strm_reservoir_src (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  strm_regs_pkg::ctrl_cfg_t    ctrl_i,
  input  logic [31:0]                 seed_i,
  input  strm_types_pkg::stall_mask_t stall_mask_i,
  strm_stream_if.source               src_o
);

  // one step: shift right, fold taps in when a 1 drops out
  function automatic logic [`STRM_DATA_W-1:0] lfsr_step(input logic [`STRM_DATA_W-1:0] s);
    logic [`STRM_DATA_W-1:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ `STRM_LFSR_POLY;
    return n;
  endfunction

  logic [`STRM_DATA_W-1:0] lfsr_q;  // next word to send
  logic [`STRM_DATA_W-1:0] data_q;
  logic                    valid_q;
  logic [2:0]              phase_q; // mask rotation, bit phase_q is current
  logic                    stall_bit;
  logic                    blocked;
  logic                    can_load;

  assign stall_bit = stall_mask_i[phase_q];
  assign blocked   = ~ctrl_i.enable | ctrl_i.force_invalid |
                     (stall_bit & ~ctrl_i.force_valid);
  assign can_load  = ~valid_q | src_o.ready; // empty or beat leaving

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lfsr_q  <= `STRM_SEED_RST;
      valid_q <= 1'b0;
      phase_q <= '0;
    end else if (ctrl_i.reseed) begin
      lfsr_q  <= seed_i; // seed goes out first
      valid_q <= 1'b0;   // pending beat dropped
      phase_q <= '0;
    end else begin
      if (ctrl_i.enable) phase_q <= phase_q + 3'd1; // rotate right by one
      if (can_load) begin
        if (!blocked) begin
          valid_q <= 1'b1;
          data_q  <= lfsr_q;
          lfsr_q  <= lfsr_step(lfsr_q); // advance only on load
        end else begin
          valid_q <= 1'b0; // bubble
        end
      end
    end
  end

  assign src_o.data  = data_q;
  assign src_o.valid = valid_q;
  assign src_o.strb  = '1; // realigner trims it

  // a stalled beat stays put unless a reseed flushes it
  a_hold_under_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (src_o.valid && !src_o.ready && !ctrl_i.reseed) |=> src_o.valid && $stable(src_o.data));

endmodule

/* logic/strm_realigner.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// zero-latency strobe realigner; counts beats per packet and
// drops the low bytes of each packet's first beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "strm_consts.svh"

module strm_realigner (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  strm_regs_pkg::pkt_cfg_t pkt_i,
  input  logic                    reseed_i,
  strm_stream_if.sink             in_s,
  strm_stream_if.source           out_s
);

  logic [15:0]           cnt_q;   // beat index inside packet
  logic [15:0]           len_eff;
  logic                  xfer;
  logic                  last_beat;
  strm_types_pkg::strb_t head_mask;

  assign len_eff   = (pkt_i.len == 16'd0) ? 16'd1 : pkt_i.len;
  assign last_beat = (cnt_q >= len_eff - 16'd1); // also catches a shrunk len
  assign xfer      = in_s.valid & out_s.ready;

  // ones above the rotation, e.g. rot 2 -> 4'b1100
  assign head_mask = strm_types_pkg::strb_t'({`STRM_STRB_W{1'b1}} << pkt_i.rot);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || reseed_i) begin
      cnt_q <= '0;
    end else if (xfer) begin
      cnt_q <= last_beat ? 16'd0 : cnt_q + 16'd1;
    end
  end

  // straight through apart from the strobe
  assign out_s.data  = in_s.data;
  assign out_s.valid = in_s.valid;
  assign in_s.ready  = out_s.ready;
  assign out_s.strb  = (cnt_q == 16'd0) ? (in_s.strb & head_mask) : in_s.strb;

endmodule

/* logic/strm_signature.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// passive stream observer; counts accepted beats and folds
// their data into a rotate-xor signature for software
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module strm_signature (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          reseed_i,
  strm_stream_if.monitor mon_s,
  output logic [31:0]   beats_o,
  output logic [31:0]   sig_o
);

  logic [31:0] beats_q;
  logic [31:0] sig_q;
  logic        xfer;

  assign xfer = mon_s.valid & mon_s.ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || reseed_i) begin
      beats_q <= '0;
      sig_q   <= '0;
    end else if (xfer) begin
      beats_q <= beats_q + 32'd1;
      sig_q   <= {sig_q[30:0], sig_q[31]} ^ mon_s.data; // rotl 1, then xor
    end
  end

  // visible to a read on the next cycle
  assign beats_o = beats_q;
  assign sig_o   = sig_q;

endmodule

/* logic/strm_gen_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream test-pattern engine top; AXI4-Lite in, one stream out,
// with source, realigner and signature behind the register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "strm_consts.svh"

module strm_gen_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [`AXIL_ADDR_W-1:0] s_axil_awaddr_i,
  input  logic                    s_axil_awvalid_i,
  output logic                    s_axil_awready_o,
  input  logic [31:0]             s_axil_wdata_i,
  input  logic [3:0]              s_axil_wstrb_i,
  input  logic                    s_axil_wvalid_i,
  output logic                    s_axil_wready_o,
  output logic [1:0]              s_axil_bresp_o,
  output logic                    s_axil_bvalid_o,
  input  logic                    s_axil_bready_i,
  input  logic [`AXIL_ADDR_W-1:0] s_axil_araddr_i,
  input  logic                    s_axil_arvalid_i,
  output logic                    s_axil_arready_o,
  output logic [31:0]             s_axil_rdata_o,
  output logic [1:0]              s_axil_rresp_o,
  output logic                    s_axil_rvalid_o,
  input  logic                    s_axil_rready_i,
  output logic [`STRM_DATA_W-1:0] strm_data_o,
  output strm_types_pkg::strb_t   strm_strb_o,
  output logic                    strm_valid_o,
  input  logic                    strm_ready_i
);

  strm_regs_pkg::ctrl_cfg_t    ctrl;
  strm_regs_pkg::pkt_cfg_t     pkt;
  strm_types_pkg::stall_mask_t stall_mask;
  logic [31:0]                 seed;
  logic [31:0]                 beats;
  logic [31:0]                 sig;

  strm_stream_if src_s (); // source -> realigner
  strm_stream_if out_s (); // realigner -> pins

  strm_ctrl u_ctrl (
    .clk_i, .rst_n_i,
    .s_axil_awaddr_i, .s_axil_awvalid_i, .s_axil_awready_o,
    .s_axil_wdata_i, .s_axil_wstrb_i, .s_axil_wvalid_i, .s_axil_wready_o,
    .s_axil_bresp_o, .s_axil_bvalid_o, .s_axil_bready_i,
    .s_axil_araddr_i, .s_axil_arvalid_i, .s_axil_arready_o,
    .s_axil_rdata_o, .s_axil_rresp_o, .s_axil_rvalid_o, .s_axil_rready_i,
    .ctrl_o(ctrl), .seed_o(seed), .stall_mask_o(stall_mask), .pkt_o(pkt),
    .beats_i(beats), .sig_i(sig)
  );

  strm_reservoir_src u_src (
    .clk_i, .rst_n_i,
    .ctrl_i(ctrl), .seed_i(seed), .stall_mask_i(stall_mask),
    .src_o(src_s.source)
  );

  strm_realigner u_realign (
    .clk_i, .rst_n_i,
    .pkt_i(pkt), .reseed_i(ctrl.reseed),
    .in_s(src_s.sink), .out_s(out_s.source)
  );

  strm_signature u_sig (
    .clk_i, .rst_n_i,
    .reseed_i(ctrl.reseed), .mon_s(out_s.monitor),
    .beats_o(beats), .sig_o(sig)
  );

  // stream pins
  assign strm_data_o  = out_s.data;
  assign strm_strb_o  = out_s.strb;
  assign strm_valid_o = out_s.valid;
  assign out_s.ready  = strm_ready_i;

endmodule

/* verif/tb_strm_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the stream pattern engine; drives the
// AXI4-Lite port and stream ready, checks data, strobes and the
// signature against a reference model of the LFSR stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "strm_consts.svh"

module tb_strm_gen;

  localparam int TMO = 200; // cycles allowed per wait loop

  logic                    clk_i = 1'b0;
  logic                    rst_n_i;
  logic [`AXIL_ADDR_W-1:0] awaddr, araddr;
  logic                    awvalid, awready, wvalid, wready, bvalid, bready;
  logic                    arvalid, arready, rvalid, rready;
  logic [31:0]             wdata, rdata;
  logic [3:0]              wstrb;
  logic [1:0]              bresp, rresp;
  logic [31:0]             s_data;
  logic [3:0]              s_strb;
  logic                    s_valid;
  logic                    s_ready = 1'b0;

  integer      seed = 32'h564e_086e;
  integer      rnd_word;
  logic        rnd_ready;     // 1 random ready, 0 hold_ready
  logic        hold_ready;
  logic        mon_en;        // model tracks the stream
  logic        was_stalled;
  logic [31:0] stalled_data;
  logic [31:0] exp_word;      // next word the model expects
  logic [31:0] exp_sig;
  int unsigned exp_beats;
  int unsigned pkt_idx;       // beat index inside the packet
  int unsigned cfg_len;
  int unsigned cfg_rot;

  strm_gen_top DUT (
    .clk_i, .rst_n_i,
    .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
    .s_axil_wdata_i(wdata), .s_axil_wstrb_i(wstrb), .s_axil_wvalid_i(wvalid),
    .s_axil_wready_o(wready), .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid),
    .s_axil_bready_i(bready), .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid),
    .s_axil_arready_o(arready), .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp),
    .s_axil_rvalid_o(rvalid), .s_axil_rready_i(rready),
    .strm_data_o(s_data), .strm_strb_o(s_strb), .strm_valid_o(s_valid),
    .strm_ready_i(s_ready)
  );

  always #50 clk_i = ~clk_i;

  // ready changes only on the falling edge
  always @(negedge clk_i) begin
    rnd_word = $random(seed); // drawn every cycle, fixed sequence
    s_ready  = rnd_ready ? rnd_word[0] : hold_ready;
  end

  // galois step, shift right and fold taps when a 1 drops out
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ `STRM_LFSR_POLY) : (s >> 1);
  endfunction

  // first beat of a packet loses its rot low bytes
  function automatic logic [3:0] exp_strb(input int unsigned idx, input int unsigned rot);
    logic [3:0] m;
    m = 4'hF;
    for (int b = 0; b < 4; b++) begin
      if (idx == 0 && b < rot) m[b] = 1'b0;
    end
    return m;
  endfunction

  task automatic report_fail();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic timed_out(input string what);
    $display("timeout while waiting for %s", what);
    report_fail();
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got == exp) else begin
      $display("ERR %s exp=%h got=%h", name, exp, got);
      report_fail();
    end
  endtask

  // sampled before the edge updates, so these are the transferring values
  always @(posedge clk_i) begin
    if (mon_en && was_stalled) begin
      assert (s_valid && s_data == stalled_data) else begin
        $display("ERR strm_data_o under stall exp=%h got=%h (valid %h)",
                 stalled_data, s_data, s_valid);
        report_fail();
      end
    end
    if (mon_en && s_valid && s_ready) begin
      check_val("strm_data_o", exp_word, s_data);
      check_val("strm_strb_o", {28'd0, exp_strb(pkt_idx, cfg_rot)}, {28'd0, s_strb});
      exp_sig = {exp_sig[30:0], exp_sig[31]} ^ exp_word; // rotl 1 then xor
      exp_word = next_lfsr(exp_word);
      exp_beats++;
      if (pkt_idx + 1 >= ((cfg_len == 0) ? 1 : cfg_len)) pkt_idx = 0; // len 0 acts as 1
      else pkt_idx++;
    end
    was_stalled  = mon_en && s_valid && !s_ready;
    stalled_data = s_data;
  end

  task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                            input logic [1:0] resp);
    int   n = 0;
    logic aw_hs, w_hs;
    @(negedge clk_i);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = 4'hF;
    wvalid  = 1'b1;
    bready  = 1'b1;
    while (awvalid || wvalid) begin
      aw_hs = awvalid && awready;
      w_hs  = wvalid && wready;
      @(negedge clk_i); // handshake on the edge in between
      if (aw_hs) awvalid = 1'b0;
      if (w_hs) wvalid = 1'b0;
      n++;
      if (n > TMO) timed_out("AXI write address and data");
    end
    n = 0;
    while (!bvalid) begin
      @(negedge clk_i);
      n++;
      if (n > TMO) timed_out("AXI write response");
    end
    check_val("s_axil_bresp_o", {30'd0, resp}, {30'd0, bresp});
    @(negedge clk_i);
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [4:0] addr, input logic [1:0] resp,
                           output logic [31:0] data);
    int   n = 0;
    logic ar_hs;
    @(negedge clk_i);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    while (arvalid) begin
      ar_hs = arready;
      @(negedge clk_i);
      if (ar_hs) arvalid = 1'b0;
      n++;
      if (n > TMO) timed_out("AXI read address");
    end
    n = 0;
    while (!rvalid) begin
      @(negedge clk_i);
      n++;
      if (n > TMO) timed_out("AXI read data");
    end
    check_val("s_axil_rresp_o", {30'd0, resp}, {30'd0, rresp});
    data = rdata;
    @(negedge clk_i);
    rready = 1'b0;
  endtask

  task automatic read_check(input logic [4:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] d;
    axil_read(addr, `AXIL_RESP_OKAY, d);
    check_val(name, exp, d);
  endtask

  task automatic wait_beats(input int unsigned target);
    int n = 0;
    while (exp_beats < target) begin
      @(negedge clk_i);
      n++;
      if (n > 5 * TMO) timed_out("accepted stream beats");
    end
  endtask

  // reseed with seed s, ctrl bits 2:0 set alongside, model restarts too
  task automatic restart(input logic [31:0] s, input logic [2:0] ctrl);
    mon_en = 1'b0;
    axil_write(strm_regs_pkg::REG_SEED, s, `AXIL_RESP_OKAY);
    axil_write(strm_regs_pkg::REG_CTRL, {28'd0, 1'b1, ctrl}, `AXIL_RESP_OKAY); // bit 3 reseed
    exp_word  = s;
    exp_sig   = '0;
    exp_beats = 0;
    pkt_idx   = 0;
    mon_en    = 1'b1;
  endtask

  task automatic test_regs();
    logic [31:0] d;
    check_val("strm_valid_o", 32'd0, {31'd0, s_valid});
    axil_write(strm_regs_pkg::REG_SEED, 32'hA5C3_0F17, `AXIL_RESP_OKAY);
    read_check(strm_regs_pkg::REG_SEED, 32'hA5C3_0F17, "SEED");
    axil_write(strm_regs_pkg::REG_STALL, 32'h0000_005A, `AXIL_RESP_OKAY);
    read_check(strm_regs_pkg::REG_STALL, 32'h0000_005A, "STALL");
    axil_write(strm_regs_pkg::REG_PKT, 32'h0002_0003, `AXIL_RESP_OKAY);
    read_check(strm_regs_pkg::REG_PKT, 32'h0002_0003, "PKT");
    axil_write(5'h18, 32'h1234_5678, `AXIL_RESP_SLVERR); // hole in the map
    axil_read(5'h1C, `AXIL_RESP_SLVERR, d);
    axil_write(strm_regs_pkg::REG_SIG, 32'hFFFF_FFFF, `AXIL_RESP_SLVERR); // read only
    read_check(strm_regs_pkg::REG_SIG, 32'd0, "SIG");
    // rejected writes must not land on an aliased register
    read_check(strm_regs_pkg::REG_STALL, 32'h0000_005A, "STALL");
    read_check(strm_regs_pkg::REG_SEED, 32'hA5C3_0F17, "SEED");
  endtask

  task automatic test_stalls();
    int unsigned n0;
    hold_ready = 1'b1;
    rnd_ready  = 1'b0;
    axil_write(strm_regs_pkg::REG_STALL, 32'h0000_00FF, `AXIL_RESP_OKAY);
    restart(32'h1357_9BDF, 3'b001);
    repeat (50) begin
      @(negedge clk_i);
      check_val("strm_valid_o", 32'd0, {31'd0, s_valid});
    end
    axil_write(strm_regs_pkg::REG_CTRL, 32'h3, `AXIL_RESP_OKAY); // force_valid
    wait_beats(10);
    axil_write(strm_regs_pkg::REG_CTRL, 32'h7, `AXIL_RESP_OKAY); // plus force_invalid
    n0 = exp_beats;
    repeat (20) @(negedge clk_i);
    assert (exp_beats <= n0 + 1) else begin
      $display("new beats kept flowing after force_invalid was set");
      report_fail();
    end
    axil_write(strm_regs_pkg::REG_CTRL, 32'h0, `AXIL_RESP_OKAY);
    axil_write(strm_regs_pkg::REG_STALL, 32'h0, `AXIL_RESP_OKAY);
  endtask

  task automatic test_signature();
    int n = 0;
    rnd_ready = 1'b1;
    restart(32'hDEAD_BEEF, 3'b001);
    wait_beats(25);
    hold_ready = 1'b0;
    rnd_ready  = 1'b0;
    while (s_ready) begin
      @(posedge clk_i);
      n++;
      if (n > TMO) timed_out("stream ready to drop");
    end
    read_check(strm_regs_pkg::REG_BEATS, exp_beats, "BEATS");
    read_check(strm_regs_pkg::REG_SIG, exp_sig, "SIG");
    mon_en = 1'b0; // reseed drops the stalled beat
    axil_write(strm_regs_pkg::REG_CTRL, 32'h8, `AXIL_RESP_OKAY);
    read_check(strm_regs_pkg::REG_BEATS, 32'd0, "BEATS");
    read_check(strm_regs_pkg::REG_SIG, 32'd0, "SIG");
  endtask

  initial begin
    rst_n_i    = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    rnd_ready  = 1'b0;
    hold_ready = 1'b0;
    mon_en     = 1'b0;
    exp_word   = '0;
    exp_sig    = '0;
    exp_beats  = 0;
    pkt_idx    = 0;
    cfg_len    = 1;
    cfg_rot    = 0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    test_regs();
    // plain LFSR order, no bubbles, len 1 rot 0 keeps full strobes
    cfg_len = 0;
    axil_write(strm_regs_pkg::REG_STALL, 32'h0, `AXIL_RESP_OKAY);
    axil_write(strm_regs_pkg::REG_PKT, 32'h0, `AXIL_RESP_OKAY);
    hold_ready = 1'b1;
    restart(32'hC0DE_1234, 3'b001);
    wait_beats(20);
    // random back-pressure
    rnd_ready = 1'b1;
    restart(32'h0BAD_F00D, 3'b001);
    wait_beats(40);
    test_stalls();
    // packets of 3, first beat drops 2 bytes
    cfg_len = 3;
    cfg_rot = 2;
    axil_write(strm_regs_pkg::REG_PKT, 32'h0002_0003, `AXIL_RESP_OKAY);
    rnd_ready = 1'b1;
    restart(32'h2468_ACE0, 3'b001);
    wait_beats(20);
    test_signature();

    $display("No errors");
    $finish;
  end

endmodule

/* all.f */
+incdir+logic
logic/strm_types_pkg.sv
logic/strm_regs_pkg.sv
logic/strm_stream_if.sv
logic/strm_ctrl.sv
logic/strm_reservoir_src.sv
logic/strm_realigner.sv
logic/strm_signature.sv
logic/strm_gen_top.sv
verif/tb_strm_gen.sv

/* run.sh */
#!/bin/sh
# build and run the stream engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_strm_gen -Mdir obj_dir -o sim_tb -f all.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation returned status $sim_status"
  exit 1
fi

if grep -q "Errors found" sim.log; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
exit 0
